/* hdl/fetch_pkg.sv */
// types and constants for next-PC selection and trap vectors
// used by the fetch stage and by anything that drives its redirect inputs
package fetch_pkg;

  // byte address and upper part of a trap vector base
  typedef logic [31:0] addr_t;
  typedef logic [23:0] trap_base_t;
  // index into the vectored interrupt table
  typedef logic [4:0]  irq_vec_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_MRET, PC_URET, PC_DRET
  } pc_mux_e;

  // kind of trap entry
  typedef enum logic [1:0] {EXC_PC_EXCEPTION, EXC_PC_IRQ, EXC_PC_DBD} exc_pc_mux_e;

  // which privilege level's base is used
  typedef enum logic {TRAP_MACHINE, TRAP_USER} trap_sel_e;

  typedef struct packed {
    logic [30:0] boot_addr;
    addr_t       jump_target;
    addr_t       branch_target;
    addr_t       mepc;
    addr_t       uepc;
    addr_t       depc;
  } pc_targets_t;

  typedef struct packed {
    trap_base_t  m_base;
    trap_base_t  u_base;
    trap_sel_e   trap_sel;
    exc_pc_mux_e exc_mux;
    irq_vec_t    irq_vec;
  } trap_cfg_t;

  // debug module entry point
  localparam addr_t DEBUG_HALT_ADDR = 32'h0000_0800;

  // --------------------
  // prefetch sizing
  // queue entries, also the cap on outstanding requests
  localparam int PREFETCH_DEPTH = 2;
  // in flight cap incl. responses still owed for a dropped stream
  localparam int INFLIGHT_MAX   = 2 * PREFETCH_DEPTH;

  typedef logic [$clog2(INFLIGHT_MAX + 1)-1:0] pf_cnt_t;
  typedef logic [$clog2(PREFETCH_DEPTH)-1:0]   pf_ptr_t;

endpackage

/* hdl/isa_pkg.sv */
// instruction encodings and the records that carry fetched words
// shared by the prefetch queue, the RVC expander and the IF/ID register
package isa_pkg;

  // one 32-bit instruction word
  typedef logic [31:0] instr_t;

  // --------------------
  // RV32I major opcodes produced by the expander
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LUI    = 7'h37;

  // --------------------
  // one buffered fetch, word plus the address it came from
  typedef struct packed {
    fetch_pkg::addr_t addr;
    instr_t           word;
  } fetch_word_t;

  // contents of the IF/ID pipeline register
  typedef struct packed {
    logic             valid;
    instr_t           instr;
    fetch_pkg::addr_t pc;
    // set when the word was a 16-bit encoding
    logic             is_compressed;
    // compressed encoding outside the supported subset
    logic             illegal_c;
  } if_id_t;

endpackage

/* hdl/pc_select.sv */
// next fetch address mux, purely combinational
// also builds the exception, interrupt and debug entry vectors
`timescale 1ns/10ps

module pc_select (
  input  fetch_pkg::pc_targets_t targets_i,
  input  fetch_pkg::trap_cfg_t   trap_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  output fetch_pkg::addr_t       fetch_addr_o
);

  fetch_pkg::trap_base_t trap_base;
  fetch_pkg::addr_t      exc_pc;
  fetch_pkg::addr_t      next_pc;

  // --------------------
  // trap vector
  always_comb begin
    // machine or user base
    if (trap_i.trap_sel == fetch_pkg::TRAP_USER) begin
      trap_base = trap_i.u_base;
    end else begin
      trap_base = trap_i.m_base;
    end

    case (trap_i.exc_mux)
      // all synchronous exceptions land on the base
      fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};
      // vectored irq, 4 bytes per line
      fetch_pkg::EXC_PC_IRQ:       exc_pc = {trap_base, 1'b0, trap_i.irq_vec, 2'b00};
      fetch_pkg::EXC_PC_DBD:       exc_pc = fetch_pkg::DEBUG_HALT_ADDR;
      default:                     exc_pc = {trap_base, 8'h00};
    endcase
  end

  // --------------------
  // next pc source
  always_comb begin
    case (pc_mux_i)
      // boot address is given in halfwords
      fetch_pkg::PC_BOOT:      next_pc = {targets_i.boot_addr, 1'b0};
      fetch_pkg::PC_JUMP:      next_pc = targets_i.jump_target;
      fetch_pkg::PC_BRANCH:    next_pc = targets_i.branch_target;
      fetch_pkg::PC_EXCEPTION: next_pc = exc_pc;
      // returns restore the saved pc
      fetch_pkg::PC_MRET:      next_pc = targets_i.mepc;
      fetch_pkg::PC_URET:      next_pc = targets_i.uepc;
      fetch_pkg::PC_DRET:      next_pc = targets_i.depc;
      default:                 next_pc = {targets_i.boot_addr, 1'b0};
    endcase
  end

  // fetches are always word aligned
  assign fetch_addr_o = {next_pc[31:2], 2'b00};

endmodule

/* hdl/prefetch_buffer.sv */
// prefetcher between the fetch controller and instruction memory
// issues word requests on req/gnt/rvalid, queues responses with their addresses,
// and drops responses that belong to a stream abandoned by a redirect
`timescale 1ns/10ps

module prefetch_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  fetch_pkg::addr_t     branch_addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output isa_pkg::fetch_word_t word_o,
  output logic                 busy_o,
  output logic                 instr_req_o,
  output fetch_pkg::addr_t     instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  isa_pkg::instr_t      instr_rdata_i
);

  // address of the next request and of the next kept response
  fetch_pkg::addr_t     next_addr_q;
  fetch_pkg::addr_t     resp_addr_q;

  // response queue
  isa_pkg::fetch_word_t queue_q [fetch_pkg::PREFETCH_DEPTH];
  fetch_pkg::pf_ptr_t   wr_ptr_q;
  fetch_pkg::pf_ptr_t   rd_ptr_q;
  fetch_pkg::pf_cnt_t   q_cnt_q;

  // granted and not yet answered, split by stream
  fetch_pkg::pf_cnt_t   out_cnt_q;
  fetch_pkg::pf_cnt_t   drop_cnt_q;

  logic queue_ok;
  logic inflight_ok;
  logic accept;
  logic drop;
  logic push;
  logic pop;

  // --------------------
  // request side
  // room left for another word once all live requests come back
  assign queue_ok    = (int'(q_cnt_q) + int'(out_cnt_q)) < fetch_pkg::PREFETCH_DEPTH;
  // bound on everything memory still owes us
  assign inflight_ok = (int'(out_cnt_q) + int'(drop_cnt_q)) < fetch_pkg::INFLIGHT_MAX;

  // a redirect empties the queue, so it only needs the in flight check
  assign instr_req_o  = req_i & inflight_ok & (branch_i | queue_ok);
  // new target goes out in the same cycle as the branch
  assign instr_addr_o = branch_i ? branch_addr_i : next_addr_q;
  assign accept       = instr_req_o & instr_gnt_i;

  // --------------------
  // response side
  // old stream responses are swallowed, incl. one arriving with the branch
  assign drop = instr_rvalid_i & (branch_i | (drop_cnt_q != '0));
  assign push = instr_rvalid_i & ~drop;
  assign pop  = valid_o & ready_i & ~branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q <= '0;
      resp_addr_q <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      q_cnt_q     <= '0;
      out_cnt_q   <= '0;
      drop_cnt_q  <= '0;
    end else if (branch_i) begin
      // every live request now belongs to the abandoned stream
      drop_cnt_q  <= out_cnt_q + drop_cnt_q - fetch_pkg::pf_cnt_t'(instr_rvalid_i);
      out_cnt_q   <= fetch_pkg::pf_cnt_t'(accept);
      q_cnt_q     <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      // first kept response will be the branch target
      resp_addr_q <= branch_addr_i;
      next_addr_q <= accept ? branch_addr_i + 32'd4 : branch_addr_i;
    end else begin
      drop_cnt_q <= drop_cnt_q - fetch_pkg::pf_cnt_t'(drop);
      out_cnt_q  <= out_cnt_q + fetch_pkg::pf_cnt_t'(accept) - fetch_pkg::pf_cnt_t'(push);
      q_cnt_q    <= q_cnt_q + fetch_pkg::pf_cnt_t'(push) - fetch_pkg::pf_cnt_t'(pop);
      if (push) begin
        wr_ptr_q    <= wr_ptr_q + 1'b1;
        resp_addr_q <= resp_addr_q + 32'd4;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // sequential stream steps one word per grant
      if (accept) begin
        next_addr_q <= next_addr_q + 32'd4;
      end
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      queue_q[wr_ptr_q].addr <= resp_addr_q;
      queue_q[wr_ptr_q].word <= instr_rdata_i;
    end
  end

  // --------------------
  // head of queue to the controller
  assign valid_o = (q_cnt_q != '0);
  assign word_o  = queue_q[rd_ptr_q];
  // memory still owes us something
  assign busy_o  = (out_cnt_q != '0) | (drop_cnt_q != '0);

endmodule

/* hdl/rvc_expander.sv */
// expands a subset of RV32C into the matching RV32I words
// full-size words pass straight through, unsupported forms raise illegal_o
`timescale 1ns/10ps

module rvc_expander (
  input  isa_pkg::instr_t instr_i,
  output isa_pkg::instr_t instr_o,
  output logic            is_compressed_o,
  output logic            illegal_o
);

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    case (instr_i[1:0])
      // --------------------
      // quadrant 0
      2'b00: begin
        case (instr_i[15:13])
          // c.lw -> lw rd', uimm(rs1')
          3'b010: instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                             2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2],
                             isa_pkg::OPC_LOAD};
          // c.sw -> sw rs2', uimm(rs1')
          3'b110: instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                             2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                             2'b00, isa_pkg::OPC_STORE};
          // c.illegal and everything else in q0
          default: illegal_o = 1'b1;
        endcase
      end

      // --------------------
      // quadrant 1
      2'b01: begin
        case (instr_i[15:13])
          // c.addi -> addi rd, rd, imm
          3'b000: instr_o = {{7{instr_i[12]}}, instr_i[6:2], instr_i[11:7], 3'b000,
                             instr_i[11:7], isa_pkg::OPC_OP_IMM};
          // c.li -> addi rd, x0, imm
          3'b010: instr_o = {{7{instr_i[12]}}, instr_i[6:2], 5'b0, 3'b000,
                             instr_i[11:7], isa_pkg::OPC_OP_IMM};
          3'b011: begin
            // rd == x2 is c.addi16sp, zero imm is reserved
            if (instr_i[11:7] == 5'd2 || {instr_i[12], instr_i[6:2]} == 6'b0) begin
              illegal_o = 1'b1;
            end else begin
              // c.lui -> lui rd, nzimm
              instr_o = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], isa_pkg::OPC_LUI};
            end
          end
          // c.j -> jal x0, offset
          3'b101: instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                             instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                             instr_i[12], {8{instr_i[12]}}, 5'b0, isa_pkg::OPC_JAL};
          // c.beqz -> beq rs1', x0, offset
          3'b110: instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b0, 2'b01,
                             instr_i[9:7], 3'b000, instr_i[11:10], instr_i[4:3],
                             instr_i[12], isa_pkg::OPC_BRANCH};
          default: illegal_o = 1'b1;
        endcase
      end

      // --------------------
      // quadrant 2, only c.mv and c.add
      2'b10: begin
        // rs2 == x0 selects jr/jalr/ebreak, not supported
        if (instr_i[15:13] != 3'b100 || instr_i[6:2] == 5'b0) begin
          illegal_o = 1'b1;
        end else if (!instr_i[12]) begin
          // c.mv -> add rd, x0, rs2
          instr_o = {7'b0, instr_i[6:2], 5'b0, 3'b000, instr_i[11:7], isa_pkg::OPC_OP};
        end else begin
          // c.add -> add rd, rd, rs2
          instr_o = {7'b0, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7],
                     isa_pkg::OPC_OP};
        end
      end

      // full size word
      default: instr_o = instr_i;
    endcase

    // nothing leaks out on an illegal form
    if (illegal_o) begin
      instr_o = '0;
    end
  end

endmodule

/* hdl/fetch_ctrl.sv */
// fetch state machine and IF/ID pipeline register
// starts the prefetcher on req_i, redirects it on pc_set_i, hands words to decode
`timescale 1ns/10ps

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  logic                 halt_if_i,
  input  logic                 id_ready_i,
  input  logic                 clear_instr_valid_i,
  input  logic                 fetch_valid_i,
  input  isa_pkg::fetch_word_t fetch_word_i,
  input  isa_pkg::instr_t      dec_instr_i,
  input  logic                 dec_compressed_i,
  input  logic                 dec_illegal_i,
  output logic                 branch_o,
  output logic                 fetch_ready_o,
  output isa_pkg::if_id_t      if_id_o,
  output logic                 perf_imiss_o
);

  typedef enum logic {IDLE, WAIT} fsm_e;

  fsm_e state_q;
  fsm_e state_d;
  // head word may go to decode this cycle
  logic word_valid;
  logic accept;

  // IF/ID register fields
  logic             valid_q;
  isa_pkg::instr_t  instr_q;
  fetch_pkg::addr_t pc_q;
  logic             compressed_q;
  logic             illegal_q;

  // --------------------
  // state machine
  always_comb begin
    state_d    = state_q;
    branch_o   = 1'b0;
    word_valid = 1'b0;

    case (state_q)
      // nothing requested yet, start at the selected address
      IDLE: begin
        if (req_i) begin
          branch_o = 1'b1;
          state_d  = WAIT;
        end
      end
      WAIT: word_valid = fetch_valid_i;
      default: state_d = IDLE;
    endcase

    // redirect wins and masks the current head word
    if (pc_set_i) begin
      branch_o   = 1'b1;
      word_valid = 1'b0;
      state_d    = WAIT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // stalled decode leaves the head word in the queue
  assign accept        = word_valid & id_ready_i & ~halt_if_i;
  assign fetch_ready_o = accept;

  // --------------------
  // IF/ID register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q      <= dec_instr_i;
      pc_q         <= fetch_word_i.addr;
      compressed_q <= dec_compressed_i;
      illegal_q    <= dec_illegal_i;
    end
  end

  assign if_id_o = '{valid: valid_q, instr: instr_q, pc: pc_q,
                     is_compressed: compressed_q, illegal_c: illegal_q};

  // miss when decode gets nothing or a redirect is starting
  assign perf_imiss_o = ~fetch_valid_i | branch_o;

endmodule

/* hdl/if_stage.sv */
// instruction fetch stage top level
// ties pc selection, prefetcher, RVC expander and fetch control to memory and decode
`timescale 1ns/10ps

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  fetch_pkg::pc_targets_t targets_i,
  input  fetch_pkg::trap_cfg_t   trap_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  logic                   pc_set_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  // instruction memory
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  isa_pkg::instr_t        instr_rdata_i,
  // decode side
  output isa_pkg::if_id_t        if_id_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  fetch_pkg::addr_t     fetch_addr;
  logic                 branch;
  logic                 fetch_valid;
  logic                 fetch_ready;
  isa_pkg::fetch_word_t fetch_word;
  isa_pkg::instr_t      dec_instr;
  logic                 dec_compressed;
  logic                 dec_illegal;

  pc_select u_pc_select (
    .targets_i    (targets_i),
    .trap_i       (trap_i),
    .pc_mux_i     (pc_mux_i),
    .fetch_addr_o (fetch_addr)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch),
    .branch_addr_i  (fetch_addr),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .word_o         (fetch_word),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  // expands the queue head before it reaches the IF/ID register
  rvc_expander u_rvc_expander (
    .instr_i         (fetch_word.word),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_o       (dec_illegal)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .fetch_valid_i       (fetch_valid),
    .fetch_word_i        (fetch_word),
    .dec_instr_i         (dec_instr),
    .dec_compressed_i    (dec_compressed),
    .dec_illegal_i       (dec_illegal),
    .branch_o            (branch),
    .fetch_ready_o       (fetch_ready),
    .if_id_o             (if_id_o),
    .perf_imiss_o        (perf_imiss_o)
  );

  // address of the word waiting at the queue head
  assign pc_if_o = fetch_word.addr;

endmodule

/* bench/instr_mem_model.sv */
// instruction memory for the fetch stage testbench
// random grant and response delays, answers in order, contents computed from the address
`timescale 1ns/10ps

module instr_mem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output isa_pkg::instr_t  rdata_o
);

  logic [31:0]      rng;
  // cycles of req still to wait before the next grant
  logic [1:0]       gnt_wait;
  int unsigned      cyc;
  int unsigned      last_due;
  int unsigned      due;
  // granted requests waiting for their response
  fetch_pkg::addr_t pend_addr [$];
  int unsigned      pend_due  [$];

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // RV32C table in the low half at 0x4000..0x4020
  // everywhere else a full-size word built from the address
  function automatic isa_pkg::instr_t mem_word(input fetch_pkg::addr_t a);
    logic [15:0] c;
    case (a)
      32'h0000_4000: c = 16'h028d;  // c.addi x5, 3
      32'h0000_4004: c = 16'h557d;  // c.li x10, -1
      32'h0000_4008: c = 16'h6185;  // c.lui x3, 1
      32'h0000_400c: c = 16'h4144;  // c.lw x9, 4(x10)
      32'h0000_4010: c = 16'hc60c;  // c.sw x11, 8(x12)
      32'h0000_4014: c = 16'ha021;  // c.j +8
      32'h0000_4018: c = 16'hc801;  // c.beqz x8, +16
      32'h0000_401c: c = 16'h873e;  // c.mv x14, x15
      32'h0000_4020: c = 16'h0000;  // c.illegal
      default: return {a[31:2], 2'b11};
    endcase
    // upper half is junk the expander must ignore
    return {a[15:0], c};
  endfunction

  assign gnt_o = req_i && (gnt_wait == 2'd0);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rng      = 32'hd386_4269;
      cyc      = 0;
      last_due = 0;
      pend_addr.delete();
      pend_due.delete();
      gnt_wait <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      cyc = cyc + 1;
      if (req_i && gnt_o) begin
        rng = xorshift32(rng);
        gnt_wait <= rng[1:0];
        // answer 1..4 cycles later, never ahead of an older request
        due = cyc + rng[3:2];
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
      end else if (req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      // --------------------
      // response channel, one word per cycle at most
      rvalid_o <= 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

endmodule

/* bench/tb_if_stage.sv */
// testbench for the instruction fetch stage
// drives boot, redirects, stalls and clears against a random-latency memory
// and checks every word that reaches the IF/ID register
`timescale 1ns/10ps

module tb_if_stage;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // about 115 words are waited for, 160 leaves margin
  localparam int TOTAL_LOADS  = 160;
  // worst case cycles per word with random stalls and drops
  localparam int WORST_CYCLES = 32;
  localparam int TIMEOUT_NS   = TOTAL_LOADS * WORST_CYCLES * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n;
  logic                   req_i;
  logic                   pc_set_i;
  logic                   halt_if_i;
  logic                   id_ready_i;
  logic                   clear_instr_valid_i;
  fetch_pkg::pc_targets_t targets;
  fetch_pkg::trap_cfg_t   trap;
  fetch_pkg::pc_mux_e     pc_mux;
  logic                   instr_req;
  fetch_pkg::addr_t       instr_addr;
  logic                   instr_gnt;
  logic                   instr_rvalid;
  isa_pkg::instr_t        instr_rdata;
  isa_pkg::if_id_t        if_id;
  fetch_pkg::addr_t       pc_if;
  logic                   if_busy;
  logic                   perf_imiss;

  int errors     = 0;
  int checks     = 0;
  int load_count = 0;
  // 0 free running, 1 random stalls, 2 held stalled
  int stall_mode = 0;
  logic [31:0] stall_rng = 32'hd386_4269;
  logic [31:0] addr_rng  = 32'hd386_4269;

  // reference tracking
  logic             started     = 1'b0;
  logic             was_load    = 1'b0;
  logic             was_clear   = 1'b0;
  logic             was_pending = 1'b0;
  fetch_pkg::addr_t pending_addr;
  fetch_pkg::addr_t exp_pc;
  isa_pkg::if_id_t  exp_word;
  isa_pkg::if_id_t  prev_if_id;

  if_stage u_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .targets_i           (targets),
    .trap_i              (trap),
    .pc_mux_i            (pc_mux),
    .pc_set_i            (pc_set_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .if_id_o             (if_id),
    .pc_if_o             (pc_if),
    .if_busy_o           (if_busy),
    .perf_imiss_o        (perf_imiss)
  );

  instr_mem_model u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata)
  );

  // --------------------
  // reference functions
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // redirect address from the vector rules, word aligned
  function automatic fetch_pkg::addr_t ref_target(input fetch_pkg::pc_targets_t t,
                                                  input fetch_pkg::trap_cfg_t c,
                                                  input fetch_pkg::pc_mux_e m);
    fetch_pkg::trap_base_t base;
    fetch_pkg::addr_t      a;
    base = (c.trap_sel == fetch_pkg::TRAP_USER) ? c.u_base : c.m_base;
    case (m)
      fetch_pkg::PC_JUMP:   a = t.jump_target;
      fetch_pkg::PC_BRANCH: a = t.branch_target;
      fetch_pkg::PC_MRET:   a = t.mepc;
      fetch_pkg::PC_URET:   a = t.uepc;
      fetch_pkg::PC_DRET:   a = t.depc;
      fetch_pkg::PC_EXCEPTION: begin
        if (c.exc_mux == fetch_pkg::EXC_PC_IRQ) begin
          a = {base, 1'b0, c.irq_vec, 2'b00};
        end else if (c.exc_mux == fetch_pkg::EXC_PC_DBD) begin
          a = fetch_pkg::DEBUG_HALT_ADDR;
        end else begin
          a = {base, 8'h00};
        end
      end
      default: a = {t.boot_addr, 1'b0};
    endcase
    return {a[31:2], 2'b00};
  endfunction

  // what decode should get for a word fetched at pc
  function automatic isa_pkg::if_id_t expected_entry(input fetch_pkg::addr_t pc);
    isa_pkg::if_id_t e;
    e.valid         = 1'b1;
    e.pc            = pc;
    e.is_compressed = 1'b1;
    e.illegal_c     = 1'b0;
    case (pc)
      // addi x5, x5, 3
      32'h0000_4000: e.instr = {12'd3, 5'd5, 3'b000, 5'd5, isa_pkg::OPC_OP_IMM};
      // addi x10, x0, -1
      32'h0000_4004: e.instr = {12'hfff, 5'd0, 3'b000, 5'd10, isa_pkg::OPC_OP_IMM};
      // lui x3, 1
      32'h0000_4008: e.instr = {20'h00001, 5'd3, isa_pkg::OPC_LUI};
      // lw x9, 4(x10)
      32'h0000_400c: e.instr = {12'd4, 5'd10, 3'b010, 5'd9, isa_pkg::OPC_LOAD};
      // sw x11, 8(x12)
      32'h0000_4010: e.instr = {7'd0, 5'd11, 5'd12, 3'b010, 5'd8, isa_pkg::OPC_STORE};
      // jal x0, +8
      32'h0000_4014: e.instr = {1'b0, 10'd4, 1'b0, 8'h00, 5'd0, isa_pkg::OPC_JAL};
      // beq x8, x0, +16
      32'h0000_4018: e.instr = {1'b0, 6'd0, 5'd0, 5'd8, 3'b000, 4'b1000, 1'b0,
                                isa_pkg::OPC_BRANCH};
      // add x14, x0, x15
      32'h0000_401c: e.instr = {7'd0, 5'd15, 5'd0, 3'b000, 5'd14, isa_pkg::OPC_OP};
      32'h0000_4020: begin
        e.instr     = '0;
        e.illegal_c = 1'b1;
      end
      default: begin
        e.instr         = {pc[31:2], 2'b11};
        e.is_compressed = 1'b0;
      end
    endcase
    return e;
  endfunction

  // --------------------
  // checking helpers
  task automatic flag_failure(input string msg);
    errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      errors++;
      $display("error %0t %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  // block until n more words reach decode
  task automatic wait_loads(input int n);
    int target;
    int cycles;
    target = load_count + n;
    cycles = 0;
    while (load_count < target && cycles < n * WORST_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    assert (load_count >= target) else flag_failure("decode did not get its words in time");
  endtask

  // one-cycle redirect strobe, sent with requests in flight where possible
  task automatic redirect(input fetch_pkg::pc_mux_e m);
    int guard;
    guard = 0;
    @(posedge clk);
    while (!if_busy && guard < 8) begin
      @(posedge clk);
      guard++;
    end
    pc_mux   <= m;
    pc_set_i <= 1'b1;
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic trap_entry(input fetch_pkg::trap_sel_e sel,
                            input fetch_pkg::exc_pc_mux_e kind,
                            input fetch_pkg::irq_vec_t vec);
    @(posedge clk);
    trap.trap_sel <= sel;
    trap.exc_mux  <= kind;
    trap.irq_vec  <= vec;
    redirect(fetch_pkg::PC_EXCEPTION);
    wait_loads(3);
  endtask

  // --------------------
  // clock, stall driver, watchdog
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      if (stall_mode == 1) begin
        stall_rng = xorshift32(stall_rng);
        id_ready_i <= stall_rng[0] | stall_rng[1];
        halt_if_i  <= stall_rng[2] & stall_rng[3] & stall_rng[4];
      end else if (stall_mode == 2) begin
        id_ready_i <= 1'b0;
        halt_if_i  <= 1'b1;
      end else begin
        id_ready_i <= 1'b1;
        halt_if_i  <= 1'b0;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, fetch stage stopped delivering words after %0d loads", load_count);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------
  // monitor checks the last edge and records this cycle's inputs
  always @(negedge clk) begin
    if (rst_n) begin
      // a request still waiting for its grant keeps its address
      if (was_pending && !pc_set_i) begin
        compare_value("instr_req", 32'd1, instr_req);
        compare_value("instr_addr", pending_addr, instr_addr);
      end
      if (was_load) begin
        exp_word = expected_entry(exp_pc);
        compare_value("if_id.valid", 32'd1, if_id.valid);
        compare_value("if_id.pc", exp_word.pc, if_id.pc);
        compare_value("if_id.instr", exp_word.instr, if_id.instr);
        compare_value("if_id.is_compressed", exp_word.is_compressed, if_id.is_compressed);
        compare_value("if_id.illegal_c", exp_word.illegal_c, if_id.illegal_c);
        exp_pc = exp_pc + 32'd4;
        load_count++;
      end else if (was_clear) begin
        compare_value("if_id.valid", 32'd0, if_id.valid);
      end else begin
        assert (if_id === prev_if_id) else flag_failure("IF/ID changed without a load");
      end
      // a new stream sends its first request in the same cycle
      if (pc_set_i || (req_i && !started)) begin
        exp_pc  = ref_target(targets, trap, pc_mux);
        started = 1'b1;
        compare_value("instr_req", 32'd1, instr_req);
        compare_value("instr_addr", exp_pc, instr_addr);
        compare_value("perf_imiss", 32'd1, perf_imiss);
      end
      // a valid head word is the next expected pc
      if (!perf_imiss) begin
        compare_value("pc_if", exp_pc, pc_if);
      end
      // it reaches decode on this edge unless decode is stalled
      was_load     = !perf_imiss && id_ready_i && !halt_if_i;
      was_clear    = clear_instr_valid_i;
      was_pending  = instr_req && !instr_gnt;
      pending_addr = instr_addr;
      prev_if_id   = if_id;
    end else begin
      prev_if_id = if_id;
    end
  end

  // --------------------
  // stimulus
  initial begin
    fetch_pkg::trap_sel_e sel;
    rst_n               = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b1;
    clear_instr_valid_i = 1'b0;
    pc_mux              = fetch_pkg::PC_BOOT;
    // boot at 0x1000, odd targets test the alignment
    targets = '{boot_addr: 31'h0000_0800, jump_target: 32'h0000_2346,
                branch_target: 32'h0000_3100, mepc: 32'h0000_5a04,
                uepc: 32'h0000_6b0a, depc: 32'h0000_7c11};
    trap    = '{m_base: 24'h000090, u_base: 24'h0000a0,
                trap_sel: fetch_pkg::TRAP_MACHINE,
                exc_mux: fetch_pkg::EXC_PC_EXCEPTION, irq_vec: 5'd0};
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("instr_req", 32'd0, instr_req);
    compare_value("if_id.valid", 32'd0, if_id.valid);
    compare_value("if_busy", 32'd0, if_busy);

    // sequential fetch from boot
    @(posedge clk);
    req_i <= 1'b1;
    wait_loads(12);

    // trap vectors with both bases
    for (int s = 0; s < 2; s++) begin
      sel = fetch_pkg::trap_sel_e'(s);
      trap_entry(sel, fetch_pkg::EXC_PC_EXCEPTION, 5'd0);
      trap_entry(sel, fetch_pkg::EXC_PC_IRQ, 5'd3);
      trap_entry(sel, fetch_pkg::EXC_PC_IRQ, 5'd31);
      trap_entry(sel, fetch_pkg::EXC_PC_DBD, 5'd0);
    end

    // returns, jump and branch
    redirect(fetch_pkg::PC_MRET);
    wait_loads(3);
    redirect(fetch_pkg::PC_URET);
    wait_loads(3);
    redirect(fetch_pkg::PC_DRET);
    wait_loads(3);
    redirect(fetch_pkg::PC_JUMP);
    wait_loads(3);
    redirect(fetch_pkg::PC_BRANCH);
    wait_loads(3);

    // compressed table
    targets.jump_target <= 32'h0000_4000;
    redirect(fetch_pkg::PC_JUMP);
    wait_loads(9);

    // random stalls, then redirects on top of them
    @(negedge clk);
    stall_mode = 1;
    wait_loads(30);
    repeat (10) begin
      addr_rng = xorshift32(addr_rng);
      targets.branch_target <= {16'h0000, addr_rng[15:2], 2'b00};
      redirect(fetch_pkg::PC_BRANCH);
      wait_loads(2);
    end

    // clear while decode is held
    @(negedge clk);
    stall_mode = 2;
    repeat (3) @(posedge clk);
    clear_instr_valid_i <= 1'b1;
    @(posedge clk);
    clear_instr_valid_i <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    stall_mode = 0;
    wait_loads(4);

    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d loads %0d", checks, errors, load_count);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/fetch_pkg.sv
hdl/isa_pkg.sv
hdl/pc_select.sv
hdl/prefetch_buffer.sv
hdl/rvc_expander.sv
hdl/fetch_ctrl.sv
hdl/if_stage.sv
bench/instr_mem_model.sv
bench/tb_if_stage.sv
